//--- src.f
cpu_pkg.sv
regfile.sv
reg_status.sv
rob.sv
operand_resolve.sv
dispatch_ctrl.sv
dispatch_core.sv
dispatch_core_props.sv
tb_dispatch_core.sv

//--- run.sh
#!/bin/sh
# Build and run the dispatch core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_dispatch_core \
	-Mdir obj_dir \
	-f src.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/Vtb_dispatch_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All checks passed" "$LOG"; then
	exit 0
fi
exit 1

//--- tb_dispatch_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch_core;
	import cpu_pkg::*;

	// About 330 dispatches at well under 10 cycles each, plus drains
	localparam int TIMEOUT_CYCLES = 4000;

	logic       clk;
	logic       rst_n;
	logic       flush;
	logic       req;
	reg_addr_t  src1;
	reg_addr_t  src2;
	reg_addr_t  dest;
	logic       has_dest;
	logic       ack;
	operand_t   op1;
	logic       op1_ready;
	operand_t   op2;
	logic       op2_ready;
	rob_index_t tag;
	logic       wb_valid;
	rob_index_t wb_tag;
	uint32_t    wb_data;
	logic       commit_valid;
	rob_index_t commit_tag;
	reg_addr_t  commit_dest;
	logic       commit_has_dest;
	uint32_t    commit_data;

	// Reference model state
	uint32_t    m_reg  [REG_NUM];
	logic       m_busy [REG_NUM];
	rob_index_t m_ptag [REG_NUM];
	logic       m_done [ROB_DEPTH];
	reg_addr_t  m_dest [ROB_DEPTH];
	logic       m_hasd [ROB_DEPTH];
	uint32_t    m_val  [ROB_DEPTH];
	rob_index_t m_head;
	rob_index_t m_tail;
	int         m_count;
	logic       m_ack;
	operand_t   e_op1;
	operand_t   e_op2;
	logic       e_rdy1;
	logic       e_rdy2;
	rob_index_t e_tag;

	// Stimulus control
	logic [15:0] lfsr;
	string       test_name;
	int          cycles = 0;
	logic        man_wb;
	rob_index_t  man_tag;
	uint32_t     man_data;
	logic        wb_rand;
	logic        do_flush;

	dispatch_core DUT (.*);

	bind dispatch_core dispatch_core_props props_inst (
		.clk,
		.rst_n,
		.req,
		.ack,
		.commit_valid,
		.commit_tag
	);

	always #50 clk = ~clk;

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			fail_stop($sformatf("[FAIL] %s %s: expected %b, actual %b",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_operand(input string what, input operand_t exp, input logic exp_rdy,
			input operand_t act, input logic act_rdy);
		if (act_rdy !== exp_rdy || act !== exp) begin
			fail_stop($sformatf("[FAIL] %s %s: expected %b/%h, actual %b/%h",
				test_name, what, exp_rdy, exp, act_rdy, act));
		end
	endtask

	task automatic check_tag(input string what, input rob_index_t exp, input rob_index_t act);
		if (act !== exp) begin
			fail_stop($sformatf("[FAIL] %s %s: expected %0d, actual %0d",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_commit(input reg_addr_t exp_dest, input uint32_t exp_data,
			input reg_addr_t act_dest, input uint32_t act_data);
		if (act_dest !== exp_dest || act_data !== exp_data) begin
			fail_stop($sformatf("[FAIL] %s commit: expected r%0d=%h, actual r%0d=%h",
				test_name, exp_dest, exp_data, act_dest, act_data));
		end
	endtask

	// Galois LFSR, taps 16 14 13 11
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// Operand as the rules define it, from pre-edge model state
	function automatic void model_operand(input reg_addr_t src, input logic wr_en,
			input reg_addr_t wr_reg, input uint32_t wr_data,
			output operand_t opnd, output logic rdy);
		rob_index_t t;
		t = m_ptag[src];
		opnd = '0;
		rdy = 1'b1;
		if (src == '0) begin
			opnd.value = '0;
		end else if (!m_busy[src]) begin
			opnd.value = (wr_en && wr_reg == src) ? wr_data : m_reg[src];
		end else if (m_done[t]) begin
			opnd.value = m_val[t];
		end else if (wb_valid && wb_tag == t) begin
			opnd.value = wb_data;
		end else begin
			rdy = 1'b0;
			opnd.pend.tag = t;
		end
	endfunction

	always @(posedge clk) begin : model_step
		logic      retire;
		logic      alloc;
		logic      wr_en;
		reg_addr_t wr_reg;
		uint32_t   wr_data;
		operand_t  o1;
		operand_t  o2;
		logic      r1;
		logic      r2;
		if (!rst_n) begin
			m_ack   <= 1'b0;
			m_head  <= '0;
			m_tail  <= '0;
			m_count <= 0;
			for (int i = 0; i < ROB_DEPTH; i++) begin
				m_done[i] <= 1'b0;
				m_val[i]  <= '0;
			end
			// Register file keeps its contents through reset
			for (int i = 0; i < REG_NUM; i++) begin
				m_busy[i] <= 1'b0;
				m_ptag[i] <= '0;
				m_reg[i]  <= (i == 0) ? '0 : DUT.regfile_inst.mem[i];
			end
		end else begin
			retire  = (m_count != 0) && m_done[m_head];
			alloc   = req && !m_ack && (m_count != ROB_DEPTH);
			wr_reg  = m_dest[m_head];
			wr_data = m_val[m_head];
			wr_en   = retire && m_hasd[m_head] && (wr_reg != '0);

			check_bit("ack", m_ack, ack);
			check_bit("commit_valid", retire, commit_valid);
			if (retire) begin
				check_tag("commit tag", m_head, commit_tag);
				check_bit("commit_has_dest", m_hasd[m_head], commit_has_dest);
				check_commit(wr_reg, wr_data, commit_dest, commit_data);
			end
			if (m_ack) begin
				check_operand("op1", e_op1, e_rdy1, op1, op1_ready);
				check_operand("op2", e_op2, e_rdy2, op2, op2_ready);
				check_tag("tag", e_tag, tag);
			end

			model_operand(src1, wr_en, wr_reg, wr_data, o1, r1);
			model_operand(src2, wr_en, wr_reg, wr_data, o2, r2);

			if (wr_en) begin
				m_reg[wr_reg] <= wr_data;
				if (m_busy[wr_reg] && m_ptag[wr_reg] == m_head) begin
					m_busy[wr_reg] <= 1'b0;
				end
			end
			if (retire) begin
				m_head <= m_head + 1'b1;
			end
			if (alloc) begin
				e_op1          <= o1;
				e_op2          <= o2;
				e_rdy1         <= r1;
				e_rdy2         <= r2;
				e_tag          <= m_tail;
				m_tail         <= m_tail + 1'b1;
				m_done[m_tail] <= 1'b0;
				m_dest[m_tail] <= dest;
				m_hasd[m_tail] <= has_dest;
				if (has_dest && dest != '0) begin
					m_busy[dest] <= 1'b1;
					m_ptag[dest] <= m_tail;
				end
			end
			if (alloc) begin
				m_ack <= 1'b1;
			end else if (m_ack && !req) begin
				m_ack <= 1'b0;
			end
			if (wb_valid) begin
				m_done[wb_tag] <= 1'b1;
				m_val[wb_tag]  <= wb_data;
			end
			m_count <= m_count + int'(alloc) - int'(retire);
			if (flush) begin
				m_head  <= '0;
				m_tail  <= '0;
				m_count <= 0;
				for (int i = 0; i < ROB_DEPTH; i++) begin
					m_done[i] <= 1'b0;
				end
				for (int i = 0; i < REG_NUM; i++) begin
					m_busy[i] <= 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_stop($sformatf("Timeout: run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	// One clock edge, with writeback and flush for the coming cycle
	task automatic tick();
		int         start;
		int         k;
		rob_index_t t;
		logic       found;
		@(posedge clk);
		flush    <= do_flush;
		wb_valid <= 1'b0;
		if (man_wb) begin
			wb_valid <= 1'b1;
			wb_tag   <= man_tag;
			wb_data  <= man_data;
			man_wb = 1'b0;
		end else if (wb_rand && !do_flush && !flush && take_bits(1)) begin
			found = 1'b0;
			start = int'(take_bits(3));
			for (int i = 0; i < ROB_DEPTH; i++) begin
				k = (start + i) % ROB_DEPTH;
				t = rob_index_t'(m_head + k);
				if (!found && k < m_count && !m_done[t] && !(wb_valid && wb_tag == t)) begin
					found = 1'b1;
					wb_valid <= 1'b1;
					wb_tag   <= t;
					wb_data  <= take_bits(32);
				end
			end
		end
		do_flush = 1'b0;
	endtask

	task automatic start_req(input reg_addr_t s1, input reg_addr_t s2,
			input reg_addr_t d, input logic hd);
		tick();
		req      <= 1'b1;
		src1     <= s1;
		src2     <= s2;
		dest     <= d;
		has_dest <= hd;
	endtask

	task automatic wait_ack();
		while (ack !== 1'b1) begin
			tick();
		end
	endtask

	task automatic release_req();
		repeat (int'(take_bits(2))) tick();
		tick();
		req <= 1'b0;
		while (ack !== 1'b0) begin
			tick();
		end
	endtask

	task automatic dispatch(input reg_addr_t s1, input reg_addr_t s2,
			input reg_addr_t d, input logic hd);
		start_req(s1, s2, d, hd);
		wait_ack();
		release_req();
	endtask

	task automatic drain();
		wb_rand = 1'b1;
		while (m_count != 0) begin
			tick();
		end
	endtask

	task automatic flush_now();
		do_flush = 1'b1;
		tick();
		tick();
	endtask

	function automatic reg_addr_t rand_reg();
		return reg_addr_t'(take_bits(5));
	endfunction

	initial begin
		rob_index_t t_a;
		rob_index_t freed;
		operand_t   exp;
		clk       = 1'b0;
		rst_n     = 1'b0;
		flush     = 1'b0;
		req       = 1'b0;
		src1      = '0;
		src2      = '0;
		dest      = '0;
		has_dest  = 1'b0;
		wb_valid  = 1'b0;
		wb_tag    = '0;
		wb_data   = '0;
		man_wb    = 1'b0;
		man_tag   = '0;
		man_data  = '0;
		wb_rand   = 1'b0;
		do_flush  = 1'b0;
		lfsr      = 16'd57796;
		test_name = "reset";
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "reset_read";
		dispatch('0, rand_reg(), '0, 1'b0);
		for (int n = 0; n < 6; n++) begin
			dispatch(rand_reg(), rand_reg(), '0, 1'b0);
		end
		drain();
		wb_rand = 1'b0;

		test_name = "dependency";
		// Oldest entry stays unwritten so later results wait in the ROB
		dispatch('0, '0, '0, 1'b0);
		dispatch('0, '0, 5'd5, 1'b1);
		t_a = e_tag;
		dispatch(5'd5, '0, '0, 1'b0);
		exp = '0;
		exp.pend.tag = t_a;
		check_operand("pending source", exp, 1'b0, op1, op1_ready);
		man_wb   = 1'b1;
		man_tag  = t_a;
		man_data = 32'h5A5A_0001;
		tick();
		tick();
		dispatch('0, 5'd5, '0, 1'b0);
		exp.value = 32'h5A5A_0001;
		check_operand("written source", exp, 1'b1, op2, op2_ready);
		dispatch('0, '0, 5'd6, 1'b1);
		// Writeback lands in the sampling cycle of the next request
		man_wb   = 1'b1;
		man_tag  = e_tag;
		man_data = 32'hC0DE_0006;
		dispatch(5'd6, 5'd6, '0, 1'b0);
		exp.value = 32'hC0DE_0006;
		check_operand("bypassed source", exp, 1'b1, op1, op1_ready);
		drain();

		test_name = "commit_order";
		wb_rand = 1'b0;
		for (int n = 0; n < 8; n++) begin
			dispatch(rand_reg(), rand_reg(), rand_reg(), 1'b1);
		end
		drain();
		for (int n = 0; n < 8; n++) begin
			dispatch(rand_reg(), rand_reg(), '0, 1'b0);
		end
		drain();

		test_name = "backpressure";
		wb_rand = 1'b0;
		for (int n = 0; n < 8; n++) begin
			dispatch(rand_reg(), rand_reg(), rand_reg(), 1'b1);
		end
		start_req(5'd1, 5'd2, 5'd3, 1'b1);
		repeat (6) tick();
		check_bit("ack while full", 1'b0, ack);
		freed    = m_head;
		man_wb   = 1'b1;
		man_tag  = freed;
		man_data = 32'hBEEF_0008;
		wait_ack();
		check_tag("reused tag", freed, tag);
		release_req();
		drain();

		test_name = "flush";
		wb_rand = 1'b0;
		dispatch('0, '0, 5'd7, 1'b1);
		dispatch('0, '0, 5'd8, 1'b1);
		dispatch(5'd7, 5'd8, 5'd9, 1'b1);
		flush_now();
		dispatch(5'd7, 5'd8, '0, 1'b0);
		check_bit("op1_ready after flush", 1'b1, op1_ready);
		check_bit("op2_ready after flush", 1'b1, op2_ready);
		check_tag("first tag after flush", '0, tag);
		drain();

		test_name = "random_mix";
		wb_rand = 1'b1;
		for (int n = 0; n < 300; n++) begin
			if (take_bits(4) == 0) begin
				flush_now();
			end
			dispatch(rand_reg(), rand_reg(), rand_reg(), 1'(take_bits(1)));
		end
		drain();

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dispatch_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_core_props (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req,
	input  logic                ack,
	input  logic                commit_valid,
	input  cpu_pkg::rob_index_t commit_tag
);
	import cpu_pkg::*;

	// Four-phase handshake order
	ack_rise_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req)
	) else $error("ack rose while req was low");

	ack_fall_needs_release: assert property (
		@(posedge clk) disable iff (!rst_n)
		$fell(ack) |-> !$past(req)
	) else $error("ack fell while req was still high");

	// Back to back commits must be different, consecutive entries
	commit_single_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		commit_valid |=> (!commit_valid ||
			commit_tag == rob_index_t'($past(commit_tag) + 1'b1))
	) else $error("commit_valid held for one entry");

	ack_low_in_reset: assert property (
		@(posedge clk) !rst_n |=> !ack
	) else $error("ack high during reset");

endmodule

`default_nettype wire

//--- dispatch_core.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,

	input  logic                req,
	input  cpu_pkg::reg_addr_t  src1,
	input  cpu_pkg::reg_addr_t  src2,
	input  cpu_pkg::reg_addr_t  dest,
	input  logic                has_dest,
	output logic                ack,
	output cpu_pkg::operand_t   op1,
	output logic                op1_ready,
	output cpu_pkg::operand_t   op2,
	output logic                op2_ready,
	output cpu_pkg::rob_index_t tag,

	input  logic                wb_valid,
	input  cpu_pkg::rob_index_t wb_tag,
	input  cpu_pkg::uint32_t    wb_data,

	output logic                commit_valid,
	output cpu_pkg::rob_index_t commit_tag,
	output cpu_pkg::reg_addr_t  commit_dest,
	output logic                commit_has_dest,
	output cpu_pkg::uint32_t    commit_data
);
	import cpu_pkg::*;

	uint32_t    rf_rdata1, rf_rdata2;
	logic       busy1, busy2;
	rob_index_t ptag1, ptag2;
	logic       rdone1, rdone2;
	uint32_t    rval1, rval2;
	operand_t   opnd1, opnd2;
	logic       ready1, ready2;

	logic       alloc;
	rob_index_t alloc_tag;
	logic       rob_full;
	logic       stat_set;
	logic       reg_we;

	assign stat_set = alloc && has_dest && (dest != '0);
	assign reg_we   = commit_valid && commit_has_dest;

	regfile regfile_inst (
		.clk,
		.rst_n,
		.we     ( reg_we      ),
		.waddr  ( commit_dest ),
		.wdata  ( commit_data ),
		.raddr1 ( src1        ),
		.raddr2 ( src2        ),
		.rdata1 ( rf_rdata1   ),
		.rdata2 ( rf_rdata2   )
	);

	reg_status reg_status_inst (
		.clk,
		.rst_n,
		.flush,
		.set_en  ( stat_set    ),
		.set_reg ( dest        ),
		.set_tag ( alloc_tag   ),
		.clr_en  ( reg_we      ),
		.clr_reg ( commit_dest ),
		.clr_tag ( commit_tag  ),
		.raddr1  ( src1        ),
		.raddr2  ( src2        ),
		.busy1,
		.busy2,
		.ptag1,
		.ptag2
	);

	rob rob_inst (
		.clk,
		.rst_n,
		.flush,
		.alloc,
		.alloc_dest     ( dest     ),
		.alloc_has_dest ( has_dest ),
		.alloc_tag,
		.full           ( rob_full ),
		.wb_valid,
		.wb_tag,
		.wb_data,
		.rtag1          ( ptag1    ),
		.rtag2          ( ptag2    ),
		.rdone1,
		.rdone2,
		.rval1,
		.rval2,
		.commit_valid,
		.commit_tag,
		.commit_dest,
		.commit_has_dest,
		.commit_data
	);

	operand_resolve operand_resolve_inst (
		.src1,
		.src2,
		.rdata1 ( rf_rdata1 ),
		.rdata2 ( rf_rdata2 ),
		.busy1,
		.busy2,
		.ptag1,
		.ptag2,
		.rdone1,
		.rdone2,
		.rval1,
		.rval2,
		.opnd1,
		.opnd2,
		.ready1,
		.ready2
	);

	dispatch_ctrl dispatch_ctrl_inst (
		.clk,
		.rst_n,
		.req,
		.ack,
		.full ( rob_full ),
		.opnd1,
		.opnd2,
		.ready1,
		.ready2,
		.alloc_tag,
		.alloc,
		.op1,
		.op2,
		.op1_ready,
		.op2_ready,
		.tag
	);

endmodule

`default_nettype wire

//--- dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                req,
	output logic                ack,

	input  logic                full,
	input  cpu_pkg::operand_t   opnd1,
	input  cpu_pkg::operand_t   opnd2,
	input  logic                ready1,
	input  logic                ready2,
	input  cpu_pkg::rob_index_t alloc_tag,
	output logic                alloc,

	output cpu_pkg::operand_t   op1,
	output cpu_pkg::operand_t   op2,
	output logic                op1_ready,
	output logic                op2_ready,
	output cpu_pkg::rob_index_t tag
);

	// New request seen while idle and the ROB can take it.
	// Ack is high right after, so this lasts one cycle per request.
	assign alloc = req && !ack && !full;

	// Two states, ack low waits for a request and ack high waits for release
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else if (alloc) begin
			ack <= 1'b1;
		end else if (ack && !req) begin
			ack <= 1'b0;
		end
	end

	// Held for the whole ack phase
	always_ff @(posedge clk) begin
		if (alloc) begin
			op1       <= opnd1;
			op2       <= opnd2;
			op1_ready <= ready1;
			op2_ready <= ready2;
			tag       <= alloc_tag;
		end
	end

endmodule

`default_nettype wire

//--- operand_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module operand_resolve (
	input  cpu_pkg::reg_addr_t  src1,
	input  cpu_pkg::reg_addr_t  src2,
	input  cpu_pkg::uint32_t    rdata1,
	input  cpu_pkg::uint32_t    rdata2,
	input  logic                busy1,
	input  logic                busy2,
	input  cpu_pkg::rob_index_t ptag1,
	input  cpu_pkg::rob_index_t ptag2,
	input  logic                rdone1,
	input  logic                rdone2,
	input  cpu_pkg::uint32_t    rval1,
	input  cpu_pkg::uint32_t    rval2,
	output cpu_pkg::operand_t   opnd1,
	output cpu_pkg::operand_t   opnd2,
	output logic                ready1,
	output logic                ready2
);
	import cpu_pkg::*;

	function automatic void resolve(
		input  reg_addr_t  src,
		input  uint32_t    rdata,
		input  logic       busy,
		input  rob_index_t ptag,
		input  logic       rdone,
		input  uint32_t    rval,
		output operand_t   opnd,
		output logic       ready
	);
		ready = 1'b1;
		if (src == '0) begin
			opnd.value = '0;
		end else if (!busy) begin
			opnd.value = rdata;
		end else if (rdone) begin
			// Producer finished but has not retired yet
			opnd.value = rval;
		end else begin
			ready         = 1'b0;
			opnd.pend.zero = '0;
			opnd.pend.tag  = ptag;
		end
	endfunction

	always_comb begin
		resolve(src1, rdata1, busy1, ptag1, rdone1, rval1, opnd1, ready1);
	end

	always_comb begin
		resolve(src2, rdata2, busy2, ptag2, rdone2, rval2, opnd2, ready2);
	end

endmodule

`default_nettype wire

//--- rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,

	input  logic                alloc,
	input  cpu_pkg::reg_addr_t  alloc_dest,
	input  logic                alloc_has_dest,
	output cpu_pkg::rob_index_t alloc_tag,
	output logic                full,

	input  logic                wb_valid,
	input  cpu_pkg::rob_index_t wb_tag,
	input  cpu_pkg::uint32_t    wb_data,

	input  cpu_pkg::rob_index_t rtag1,
	input  cpu_pkg::rob_index_t rtag2,
	output logic                rdone1,
	output logic                rdone2,
	output cpu_pkg::uint32_t    rval1,
	output cpu_pkg::uint32_t    rval2,

	output logic                commit_valid,
	output cpu_pkg::rob_index_t commit_tag,
	output cpu_pkg::reg_addr_t  commit_dest,
	output logic                commit_has_dest,
	output cpu_pkg::uint32_t    commit_data
);
	import cpu_pkg::*;

	logic [ROB_DEPTH-1:0] done;
	reg_addr_t            dest_q     [ROB_DEPTH];
	logic                 has_dest_q [ROB_DEPTH];
	uint32_t              value_q    [ROB_DEPTH];

	rob_index_t           head;
	rob_index_t           tail;
	logic [ROB_CW-1:0]    count;

	logic                 retire;
	logic                 hit1;
	logic                 hit2;

	assign full      = (count == ROB_CW'(ROB_DEPTH));
	assign alloc_tag = tail;
	assign retire    = (count != '0) && done[head];

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (alloc) begin
				tail       <= tail + 1'b1;
				done[tail] <= 1'b0;
			end
			if (wb_valid) begin
				done[wb_tag] <= 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
			end
			count <= count + ROB_CW'(alloc) - ROB_CW'(retire);
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			dest_q[tail]     <= alloc_dest;
			has_dest_q[tail] <= alloc_has_dest;
		end
		if (wb_valid) begin
			value_q[wb_tag] <= wb_data;
		end
	end

	// Tag reads see a result landing on the CDB this cycle
	assign hit1   = wb_valid && (wb_tag == rtag1);
	assign hit2   = wb_valid && (wb_tag == rtag2);
	assign rdone1 = done[rtag1] || hit1;
	assign rdone2 = done[rtag2] || hit2;
	assign rval1  = hit1 ? wb_data : value_q[rtag1];
	assign rval2  = hit2 ? wb_data : value_q[rtag2];

	// Head retires at the edge that ends this cycle
	assign commit_valid    = retire;
	assign commit_tag      = head;
	assign commit_dest     = dest_q[head];
	assign commit_has_dest = has_dest_q[head];
	assign commit_data     = value_q[head];

endmodule

`default_nettype wire

//--- reg_status.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                set_en,
	input  cpu_pkg::reg_addr_t  set_reg,
	input  cpu_pkg::rob_index_t set_tag,
	input  logic                clr_en,
	input  cpu_pkg::reg_addr_t  clr_reg,
	input  cpu_pkg::rob_index_t clr_tag,
	input  cpu_pkg::reg_addr_t  raddr1,
	input  cpu_pkg::reg_addr_t  raddr2,
	output logic                busy1,
	output logic                busy2,
	output cpu_pkg::rob_index_t ptag1,
	output cpu_pkg::rob_index_t ptag2
);
	import cpu_pkg::*;

	logic [REG_NUM-1:0] busy;
	rob_index_t         ptag [REG_NUM];
	logic               clr_hit;
	logic               set_act;

	// Only the youngest producer may release the register
	assign clr_hit = clr_en && busy[clr_reg] && (ptag[clr_reg] == clr_tag);
	assign set_act = set_en && (set_reg != '0);

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			busy <= '0;
		end else begin
			if (clr_hit) begin
				busy[clr_reg] <= 1'b0;
			end
			// Later assignment, so a new claim beats the release
			if (set_act) begin
				busy[set_reg] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (set_act) begin
			ptag[set_reg] <= set_tag;
		end
	end

	assign busy1 = busy[raddr1];
	assign busy2 = busy[raddr2];
	assign ptag1 = ptag[raddr1];
	assign ptag2 = ptag[raddr2];

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::uint32_t   wdata,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	output cpu_pkg::uint32_t   rdata1,
	output cpu_pkg::uint32_t   rdata2
);
	import cpu_pkg::*;

	uint32_t mem [REG_NUM];
	logic    wr_act;

	// Register 0 is never stored
	assign wr_act = we && (waddr != '0);

	// Architectural state survives reset, only writes are held off
	always_ff @(posedge clk) begin
		if (rst_n && wr_act) begin
			mem[waddr] <= wdata;
		end
	end

	// Write-first reads
	assign rdata1 = (raddr1 == '0) ? '0 :
	                (wr_act && (waddr == raddr1)) ? wdata : mem[raddr1];

	assign rdata2 = (raddr2 == '0) ? '0 :
	                (wr_act && (waddr == raddr2)) ? wdata : mem[raddr2];

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Sizes
	localparam int DATA_W    = 32;
	localparam int REG_NUM   = 32;
	localparam int ROB_DEPTH = 8;

	localparam int REG_AW = $clog2(REG_NUM);
	localparam int ROB_AW = $clog2(ROB_DEPTH);

	// Occupancy counter needs one extra bit to tell full from empty
	localparam int ROB_CW = ROB_AW + 1;

	// Scalar types
	typedef logic [DATA_W-1:0] uint32_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [ROB_AW-1:0] rob_index_t;

	// Source operand word.
	// The ready bit next to it picks the reading: ready gives the value,
	// not ready gives the tag of the ROB entry that will produce it.
	typedef union packed {
		uint32_t value;
		struct packed {
			logic [DATA_W-ROB_AW-1:0] zero;
			rob_index_t               tag;
		} pend;
	} operand_t;

endpackage

`default_nettype wire
